// File: build.f
hdl/stream_pkg.sv
hdl/app_reg_pkg.sv
hdl/app_ifs.sv
hdl/app_ctrl_regs.sv
hdl/igr_port_relabel.sv
hdl/tdest_remap.sv
hdl/rss_meta_gen.sv
hdl/app_datapath_top.sv
bench/app_datapath_chk.sv
bench/tb_app_datapath.sv

// File: bench/tb_app_datapath.sv
`default_nettype none
`timescale 1ns/1ns

module tb_app_datapath;
    import stream_pkg::*;
    import app_reg_pkg::*;

    localparam int DATA_W     = 64;
    localparam int KEEP_W     = DATA_W / 8;
    localparam int LATENCY    = 3;
    localparam int WAIT_LIMIT = 200;

    // Expected output beat and the cycle it is due in
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        port_t             tdest;
        logic              rss;
        rss_entropy_t      entropy;
        logic [31:0]       due;
    } beat_t;

    logic                tb;
    logic                rst_n;
    logic                reg_wr_en;
    reg_addr_t           reg_addr;
    reg_data_t           reg_wr_data;
    logic                s_tvalid;
    logic [DATA_W-1:0]   s_tdata;
    logic [KEEP_W-1:0]   s_tkeep;
    logic                s_tlast;
    port_t               s_tid;
    logic                m_tvalid;
    logic [DATA_W-1:0]   m_tdata;
    logic [KEEP_W-1:0]   m_tkeep;
    logic                m_tlast;
    port_t               m_tdest;
    logic                m_rss_enable;
    rss_entropy_t        m_rss_entropy;

    // Register model
    logic                mdl_en;
    port_t               mdl_sw_tid;
    port_t               mdl_remap [NUM_PORTS];

    beat_t               exp_q [$];
    int                  cycle = 0;
    int                  errors = 0;
    int                  checks = 0;
    string               cur_test = "reset";
    logic [15:0]         lfsr_state;
    // Last beat seen at the output
    port_t               obs_tdest;
    logic                obs_rss;
    rss_entropy_t        obs_entropy;
    int                  obs_beats = 0;

    app_datapath_top #(.DATA_W(DATA_W)) u_dut (
        .tb (tb), .rst_n (rst_n),
        .reg_wr_en (reg_wr_en), .reg_addr (reg_addr), .reg_wr_data (reg_wr_data),
        .s_tvalid (s_tvalid), .s_tdata (s_tdata), .s_tkeep (s_tkeep),
        .s_tlast (s_tlast), .s_tid (s_tid),
        .m_tvalid (m_tvalid), .m_tdata (m_tdata), .m_tkeep (m_tkeep),
        .m_tlast (m_tlast), .m_tdest (m_tdest),
        .m_rss_enable (m_rss_enable), .m_rss_entropy (m_rss_entropy)
    );

    initial begin
        tb = 1'b0;
        forever #10 tb = ~tb;
    end

    always @(posedge tb) begin
        cycle <= cycle + 1;
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================
    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 16'hB400;
        end
        return nxt;
    endfunction

    // One LFSR step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    task automatic next_cycle;
        @(posedge tb);
        #2;
    endtask

    task automatic check_field(input string field, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        checks++;
        if (exp_val !== act_val) begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", cur_test, field, exp_val, act_val);
        end
    endtask

    // Register write, model follows the address map
    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr_en   = 1'b1;
        reg_addr    = addr;
        reg_wr_data = data;
        if (addr == OFFSET_IGR_SW_TID) begin
            mdl_en     = data[2];
            mdl_sw_tid = data[1:0];
        end
        for (int n = 0; n < NUM_PORTS; n++) begin
            if (addr == OFFSET_TDEST_REMAP_BASE + 8'(4 * n)) begin
                mdl_remap[n] = data[1:0];
            end
        end
        next_cycle();
        reg_wr_en = 1'b0;
    endtask

    // Drive one beat and queue what should come out
    task automatic send_beat(input port_t tid, input logic [DATA_W-1:0] data,
                             input logic [KEEP_W-1:0] keep, input logic last);
        beat_t exp_beat;
        port_t eff_tid;
        eff_tid          = mdl_en ? mdl_sw_tid : tid;
        exp_beat.data    = data;
        exp_beat.keep    = keep;
        exp_beat.last    = last;
        exp_beat.tdest   = mdl_remap[eff_tid];
        // Host ports 2 and 3 get RSS metadata
        exp_beat.rss     = (exp_beat.tdest == 2'd2) || (exp_beat.tdest == 2'd3);
        exp_beat.entropy = exp_beat.rss ? rss_entropy_t'(eff_tid) : '0;
        exp_beat.due     = cycle + LATENCY;
        exp_q.push_back(exp_beat);
        s_tvalid = 1'b1;
        s_tdata  = data;
        s_tkeep  = keep;
        s_tlast  = last;
        s_tid    = tid;
        next_cycle();
    endtask

    task automatic idle_inputs;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    task automatic wait_drain;
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout in %s: %0d output beats never arrived", cur_test, exp_q.size());
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Regression failed");
            $finish;
        end
    endtask

    // One-beat packet, then the literal expected metadata
    task automatic send_single(input port_t tid, input port_t exp_tdest,
                               input logic exp_rss, input rss_entropy_t exp_entropy);
        send_beat(tid, rand_bits(DATA_W), rand_bits(KEEP_W), 1'b1);
        idle_inputs();
        wait_drain();
        check_field("tdest", exp_tdest, obs_tdest);
        check_field("rss_enable", exp_rss, obs_rss);
        check_field("rss_entropy", exp_entropy, obs_entropy);
    endtask

    // ============================================================
    // Output monitor
    // ============================================================
    always @(negedge tb) begin
        logic  head_due;
        beat_t head;
        if (rst_n) begin
            head_due = (exp_q.size() > 0) && (exp_q[0].due == cycle);
            if (m_tvalid && !head_due) begin
                errors++;
                $display("Error in %s: unexpected output beat at cycle %0d", cur_test, cycle);
            end else if (!m_tvalid && head_due) begin
                errors++;
                $display("Error in %s: output beat missing at cycle %0d", cur_test, cycle);
                void'(exp_q.pop_front());
            end else if (m_tvalid) begin
                head = exp_q.pop_front();
                check_field("tdata", head.data, m_tdata);
                check_field("tkeep", head.keep, m_tkeep);
                check_field("tlast", head.last, m_tlast);
                check_field("tdest", head.tdest, m_tdest);
                check_field("rss_enable", head.rss, m_rss_enable);
                check_field("rss_entropy", head.entropy, m_rss_entropy);
                obs_tdest   = m_tdest;
                obs_rss     = m_rss_enable;
                obs_entropy = m_rss_entropy;
                obs_beats++;
            end
        end
    end

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic test_reset_defaults;
        cur_test = "reset_defaults";
        send_single(2'd1, 2'd1, 1'b0, 12'd0);
    endtask

    task automatic test_relabel_host0;
        cur_test = "relabel_host0";
        // Enable bit 2, software tid 2
        reg_write(OFFSET_IGR_SW_TID, 32'h6);
        reg_write(OFFSET_TDEST_REMAP_BASE + 8'h08, 32'd2);
        send_single(2'd0, 2'd2, 1'b1, 12'd2);
    endtask

    task automatic test_redirect_host1;
        cur_test = "redirect_host1";
        reg_write(OFFSET_TDEST_REMAP_BASE + 8'h08, 32'd3);
        send_single(2'd1, 2'd3, 1'b1, 12'd2);
    endtask

    task automatic test_relabel_src3;
        cur_test = "relabel_src3";
        reg_write(OFFSET_IGR_SW_TID, 32'h7);
        reg_write(OFFSET_TDEST_REMAP_BASE + 8'h0C, 32'd2);
        send_single(2'd0, 2'd2, 1'b1, 12'd3);
        reg_write(OFFSET_TDEST_REMAP_BASE + 8'h0C, 32'd3);
        send_single(2'd1, 2'd3, 1'b1, 12'd3);
    endtask

    task automatic test_back_to_back;
        int    nbeats;
        int    total;
        int    start;
        port_t tid;
        cur_test = "back_to_back";
        total    = 0;
        start    = obs_beats;
        // Relabel off so the random tid drives the remap
        reg_write(OFFSET_IGR_SW_TID, 32'h0);
        for (int p = 0; p < 6; p++) begin
            nbeats = int'(rand_bits(2)) + 1;
            tid    = port_t'(rand_bits(2));
            for (int b = 0; b < nbeats; b++) begin
                send_beat(tid, rand_bits(DATA_W), rand_bits(KEEP_W), b == nbeats - 1);
            end
            total += nbeats;
        end
        idle_inputs();
        wait_drain();
        check_field("beat count", total, obs_beats - start);
    endtask

    task automatic test_network_remap;
        cur_test = "network_remap";
        reg_write(OFFSET_TDEST_REMAP_BASE + 8'h04, 32'd0);
        send_single(2'd1, 2'd0, 1'b0, 12'd0);
        // Unmapped and misaligned addresses
        reg_write(8'h20, 32'h3);
        reg_write(8'h04, 32'h7);
        reg_write(8'h11, 32'h3);
        send_single(2'd1, 2'd0, 1'b0, 12'd0);
        send_single(2'd0, 2'd0, 1'b0, 12'd0);
        send_single(2'd2, 2'd3, 1'b1, 12'd2);
    endtask

    initial begin
        rst_n       = 1'b0;
        reg_wr_en   = 1'b0;
        reg_addr    = '0;
        reg_wr_data = '0;
        s_tvalid    = 1'b0;
        s_tdata     = '0;
        s_tkeep     = '0;
        s_tlast     = 1'b0;
        s_tid       = '0;
        lfsr_state  = 16'd40488;
        // Model reset state, identity remap
        mdl_en      = 1'b0;
        mdl_sw_tid  = '0;
        for (int n = 0; n < NUM_PORTS; n++) begin
            mdl_remap[n] = port_t'(n);
        end
        repeat (4) @(posedge tb);
        #2;
        rst_n = 1'b1;
        next_cycle();

        test_reset_defaults();
        test_relabel_host0();
        test_redirect_host1();
        test_relabel_src3();
        test_back_to_back();
        test_network_remap();

        next_cycle();
        errors += u_dut.u_chk.assert_fails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/app_datapath_chk.sv
`default_nettype none
`timescale 1ns/1ns

module app_datapath_chk (
    input logic              tb,
    input logic              rst_n,
    input logic              m_tvalid,
    input logic              m_rss_enable,
    input stream_pkg::port_t m_tdest
);
    import stream_pkg::*;

    // Assertion failures seen so far
    int assert_fails = 0;

    // Outputs quiet while reset is held
    reset_quiet: assert property (@(posedge tb) !rst_n |-> (!m_tvalid && !m_rss_enable))
        else begin
            assert_fails++;
            $error("m_tvalid or m_rss_enable high during reset");
        end

    // RSS flag only rides on a valid beat
    rss_needs_valid: assert property (@(posedge tb) disable iff (!rst_n)
        m_rss_enable |-> m_tvalid)
        else begin
            assert_fails++;
            $error("m_rss_enable high without m_tvalid");
        end

    // RSS flag only for host ports
    rss_host_only: assert property (@(posedge tb) disable iff (!rst_n)
        m_rss_enable |-> (m_tdest == PORT_HOST_0 || m_tdest == PORT_HOST_1))
        else begin
            assert_fails++;
            $error("m_rss_enable high for a network port");
        end

endmodule

bind app_datapath_top app_datapath_chk u_chk (
    .tb           (tb),
    .rst_n        (rst_n),
    .m_tvalid     (m_tvalid),
    .m_rss_enable (m_rss_enable),
    .m_tdest      (m_tdest)
);

`default_nettype wire

// File: hdl/app_datapath_top.sv
`default_nettype none
`timescale 1ns/1ns

module app_datapath_top #(
    parameter int DATA_W = $bits(stream_pkg::tdata_t)
) (
    input  logic                       tb,
    input  logic                       rst_n,

    // Register write port
    input  logic                       reg_wr_en,
    input  app_reg_pkg::reg_addr_t     reg_addr,
    input  app_reg_pkg::reg_data_t     reg_wr_data,

    // Ingress stream
    input  logic                       s_tvalid,
    input  logic [DATA_W-1:0]          s_tdata,
    input  logic [DATA_W/8-1:0]        s_tkeep,
    input  logic                       s_tlast,
    input  stream_pkg::port_t          s_tid,

    // Egress stream with RSS metadata
    output logic                       m_tvalid,
    output logic [DATA_W-1:0]          m_tdata,
    output logic [DATA_W/8-1:0]        m_tkeep,
    output logic                       m_tlast,
    output stream_pkg::port_t          m_tdest,
    output logic                       m_rss_enable,
    output stream_pkg::rss_entropy_t   m_rss_entropy
);

    // ============================================================
    // Stage links
    // ============================================================
    // s0 ingress, s1 after relabel, s2 after remap
    axis_pkt_if #(.DATA_W(DATA_W)) s0 ();
    axis_pkt_if #(.DATA_W(DATA_W)) s1 ();
    axis_pkt_if #(.DATA_W(DATA_W)) s2 ();

    app_cfg_if cfg_if ();

    assign s0.tvalid = s_tvalid;
    assign s0.tdata  = s_tdata;
    assign s0.tkeep  = s_tkeep;
    assign s0.tlast  = s_tlast;
    assign s0.tid    = s_tid;
    // Output port unknown on ingress
    assign s0.tdest  = '0;

    // Software registers
    app_ctrl_regs u_ctrl (
        .tb          (tb),
        .rst_n       (rst_n),
        .reg_wr_en   (reg_wr_en),
        .reg_addr    (reg_addr),
        .reg_wr_data (reg_wr_data),
        .cfg         (cfg_if.ctrl)
    );

    // ============================================================
    // Datapath, one cycle per stage
    // ============================================================
    igr_port_relabel #(.DATA_W(DATA_W)) u_relabel (
        .tb      (tb),
        .rst_n   (rst_n),
        .cfg     (cfg_if.stage),
        .in_pkt  (s0.dst),
        .out_pkt (s1.src)
    );

    tdest_remap #(.DATA_W(DATA_W)) u_remap (
        .tb      (tb),
        .rst_n   (rst_n),
        .cfg     (cfg_if.stage),
        .in_pkt  (s1.dst),
        .out_pkt (s2.src)
    );

    rss_meta_gen #(.DATA_W(DATA_W)) u_rss (
        .tb            (tb),
        .rst_n         (rst_n),
        .in_pkt        (s2.dst),
        .m_tvalid      (m_tvalid),
        .m_tdata       (m_tdata),
        .m_tkeep       (m_tkeep),
        .m_tlast       (m_tlast),
        .m_tdest       (m_tdest),
        .m_rss_enable  (m_rss_enable),
        .m_rss_entropy (m_rss_entropy)
    );

endmodule

`default_nettype wire

// File: hdl/rss_meta_gen.sv
`default_nettype none
`timescale 1ns/1ns

module rss_meta_gen #(
    parameter int DATA_W = $bits(stream_pkg::tdata_t)
) (
    input  logic                       tb,
    input  logic                       rst_n,
    axis_pkt_if.dst                    in_pkt,
    output logic                       m_tvalid,
    output logic [DATA_W-1:0]          m_tdata,
    output logic [DATA_W/8-1:0]        m_tkeep,
    output logic                       m_tlast,
    output stream_pkg::port_t          m_tdest,
    output logic                       m_rss_enable,
    output stream_pkg::rss_entropy_t   m_rss_entropy
);
    import stream_pkg::*;

    // Valid beat headed for one of the host ports
    logic host_bound;

    assign host_bound = in_pkt.tvalid &&
                        (in_pkt.tdest == PORT_HOST_0 || in_pkt.tdest == PORT_HOST_1);

    // ============================================================
    // Control outputs
    // ============================================================
    always_ff @(posedge tb or negedge rst_n) begin
        if (!rst_n) begin
            m_tvalid     <= 1'b0;
            m_rss_enable <= 1'b0;
        end else begin
            m_tvalid     <= in_pkt.tvalid;
            m_rss_enable <= host_bound;
        end
    end

    // Payload and metadata
    always_ff @(posedge tb) begin
        m_tdata       <= in_pkt.tdata;
        m_tkeep       <= in_pkt.tkeep;
        m_tlast       <= in_pkt.tlast;
        m_tdest       <= in_pkt.tdest;
        // Entropy is the source port, zero otherwise
        m_rss_entropy <= host_bound ? rss_entropy_t'(in_pkt.tid) : '0;
    end

endmodule

`default_nettype wire

// File: hdl/tdest_remap.sv
`default_nettype none
`timescale 1ns/1ns

module tdest_remap #(
    parameter int DATA_W = $bits(stream_pkg::tdata_t)
) (
    input  logic     tb,
    input  logic     rst_n,
    app_cfg_if.stage cfg,
    axis_pkt_if.dst  in_pkt,
    axis_pkt_if.src  out_pkt
);
    import stream_pkg::*;

    // Stage register
    logic                valid_q;
    logic [DATA_W-1:0]   data_q;
    logic [DATA_W/8-1:0] keep_q;
    logic                last_q;
    port_t               tid_q;
    port_t               tdest_q;

    always_ff @(posedge tb or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_pkt.tvalid;
        end
    end

    // ============================================================
    // Table lookup
    // ============================================================
    // Incoming tdest is dropped and replaced by the table entry
    always_ff @(posedge tb) begin
        data_q  <= in_pkt.tdata;
        keep_q  <= in_pkt.tkeep;
        last_q  <= in_pkt.tlast;
        tid_q   <= in_pkt.tid;
        // Indexed by effective source port
        tdest_q <= cfg.remap[in_pkt.tid];
    end

    assign out_pkt.tvalid = valid_q;
    assign out_pkt.tdata  = data_q;
    assign out_pkt.tkeep  = keep_q;
    assign out_pkt.tlast  = last_q;
    assign out_pkt.tid    = tid_q;
    assign out_pkt.tdest  = tdest_q;

endmodule

`default_nettype wire

// File: hdl/igr_port_relabel.sv
`default_nettype none
`timescale 1ns/1ns

module igr_port_relabel #(
    parameter int DATA_W = $bits(stream_pkg::tdata_t)
) (
    input  logic     tb,
    input  logic     rst_n,
    app_cfg_if.stage cfg,
    axis_pkt_if.dst  in_pkt,
    axis_pkt_if.src  out_pkt
);
    import stream_pkg::*;

    // Stage register
    logic                valid_q;
    logic [DATA_W-1:0]   data_q;
    logic [DATA_W/8-1:0] keep_q;
    logic                last_q;
    port_t               tid_q;

    // Beat valid, cleared by reset
    always_ff @(posedge tb or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_pkt.tvalid;
        end
    end

    // Payload
    always_ff @(posedge tb) begin
        data_q  <= in_pkt.tdata;
        keep_q  <= in_pkt.tkeep;
        last_q  <= in_pkt.tlast;
        // Software id wins when enabled
        tid_q   <= cfg.sw_tid_en ? cfg.sw_tid : in_pkt.tid;
    end

    assign out_pkt.tvalid = valid_q;
    assign out_pkt.tdata  = data_q;
    assign out_pkt.tkeep  = keep_q;
    assign out_pkt.tlast  = last_q;
    assign out_pkt.tid    = tid_q;
    // No output port yet
    assign out_pkt.tdest  = '0;

endmodule

`default_nettype wire

// File: hdl/app_ctrl_regs.sv
`default_nettype none
`timescale 1ns/1ns

module app_ctrl_regs (
    input  logic                   tb,
    input  logic                   rst_n,
    input  logic                   reg_wr_en,
    input  app_reg_pkg::reg_addr_t reg_addr,
    input  app_reg_pkg::reg_data_t reg_wr_data,
    app_cfg_if.ctrl                cfg
);
    import stream_pkg::*;
    import app_reg_pkg::*;

    // Relabel control
    logic  sw_tid_en_q;
    port_t sw_tid_q;

    // Remap table
    port_t remap_q [NUM_PORTS];

    // ============================================================
    // Register writes
    // ============================================================
    // New value is live right after the sampling edge
    always_ff @(posedge tb or negedge rst_n) begin
        if (!rst_n) begin
            // Relabel off
            sw_tid_en_q <= 1'b0;
            sw_tid_q    <= '0;
            // Identity remap
            for (int n = 0; n < NUM_PORTS; n++) begin
                remap_q[n] <= port_t'(n);
            end
        end else if (reg_wr_en) begin
            if (reg_addr == OFFSET_IGR_SW_TID) begin
                sw_tid_en_q <= reg_wr_data[IGR_SW_TID_EN_BIT];
                sw_tid_q    <= reg_wr_data[$bits(port_t)-1:0];
            end
            // One compare per table entry
            for (int n = 0; n < NUM_PORTS; n++) begin
                if (reg_addr == tdest_remap_addr(n)) begin
                    remap_q[n] <= reg_wr_data[$bits(port_t)-1:0];
                end
            end
            // Any other address falls through with no effect
        end
    end

    // ============================================================
    // Configuration out
    // ============================================================
    assign cfg.sw_tid_en = sw_tid_en_q;
    assign cfg.sw_tid    = sw_tid_q;

    // Table copied entry by entry
    always_comb begin
        for (int n = 0; n < NUM_PORTS; n++) begin
            cfg.remap[n] = remap_q[n];
        end
    end

endmodule

`default_nettype wire

// File: hdl/app_ifs.sv
`default_nettype none
`timescale 1ns/1ns

// ============================================================
// Packet stream between datapath stages
// ============================================================
interface axis_pkt_if #(
    parameter int DATA_W = $bits(stream_pkg::tdata_t)
);
    import stream_pkg::*;

    logic                tvalid;
    logic [DATA_W-1:0]   tdata;
    // One enable bit per byte lane
    logic [DATA_W/8-1:0] tkeep;
    logic                tlast;
    // Source port
    port_t               tid;
    // Output port, filled in by the remap stage
    port_t               tdest;

    // Driving stage
    modport src (
        output tvalid, tdata, tkeep, tlast, tid, tdest
    );

    // Receiving stage
    modport dst (
        input tvalid, tdata, tkeep, tlast, tid, tdest
    );

endinterface

// ============================================================
// Configuration from control block to stages
// ============================================================
interface app_cfg_if;
    import stream_pkg::*;

    // Ingress relabel
    logic  sw_tid_en;
    port_t sw_tid;
    // Source port to output port table
    port_t remap [NUM_PORTS];

    modport ctrl  (output sw_tid_en, sw_tid, remap);
    modport stage (input sw_tid_en, sw_tid, remap);

endinterface

`default_nettype wire

// File: hdl/app_reg_pkg.sv
`default_nettype none

package app_reg_pkg;

    // Register bus widths
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // ============================================================
    // Address map
    // ============================================================
    // Ingress relabel control, bit 2 enable, bits 1:0 software tid
    localparam reg_addr_t OFFSET_IGR_SW_TID   = 8'h00;
    localparam int        IGR_SW_TID_EN_BIT   = 2;

    // Remap table, one word per source port
    localparam reg_addr_t OFFSET_TDEST_REMAP_BASE = 8'h10;
    localparam int        TDEST_REMAP_STRIDE      = 4;

    // Byte address of remap entry n
    function automatic reg_addr_t tdest_remap_addr(input int unsigned n);
        return OFFSET_TDEST_REMAP_BASE + reg_addr_t'(TDEST_REMAP_STRIDE * n);
    endfunction

endpackage

`default_nettype wire

// File: hdl/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // ============================================================
    // Stream geometry
    // ============================================================
    // Default beat width, eight bytes
    localparam int STREAM_DATA_W = 64;

    // Two network ports and two host ports
    localparam int NUM_PORTS = 4;

    typedef logic [STREAM_DATA_W-1:0]   tdata_t;
    typedef logic [STREAM_DATA_W/8-1:0] tkeep_t;

    // Port id, 0 and 1 are network, 2 and 3 are host
    typedef logic [1:0] port_t;

    // RSS entropy carried with host-bound packets
    typedef logic [11:0] rss_entropy_t;

    // ============================================================
    // Host port ids
    // ============================================================
    localparam port_t PORT_HOST_0 = 2'd2;
    localparam port_t PORT_HOST_1 = 2'd3;

endpackage

`default_nettype wire
